// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter bit M_EXT = 1'b1  // Include the RV32M decoder
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  rv_decode_pkg::instr_t instr_i,
  input  logic                  illegal_c_insn_i,
  input  logic                  instr_fault_i,
  output rv_decode_pkg::id_ex_t ex_o   // Two edges after the input sample
);

  import rv_decode_pkg::*;

  if_id_t        if_id;        // IF/ID register contents
  decoder_ctrl_t decode_ctrl;  // Combinational decode of if_id

  if_id_reg if_id_reg_i (
    .clk              (clk),
    .reset_i          (reset_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .instr_fault_i    (instr_fault_i),
    .if_id_o          (if_id)
  );

  decoder #(
    .M_EXT (M_EXT)
  ) decoder_i (
    .if_id_i        (if_id),
    .decoder_ctrl_o (decode_ctrl)
  );

  id_ex_reg id_ex_reg_i (
    .clk     (clk),
    .reset_i (reset_i),
    .if_id_i (if_id),
    .ctrl_i  (decode_ctrl),
    .ex_o    (ex_o)
  );

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

module decoder #(
  parameter bit M_EXT = 1'b1
) (
  input  rv_decode_pkg::if_id_t        if_id_i,
  output rv_decode_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import rv_decode_pkg::*;

  decoder_ctrl_t decoder_i_ctrl;
  decoder_ctrl_t decoder_m_ctrl;
  decoder_ctrl_t decoder_ctrl_mux;  // After priority and illegal_c

  // Base set, always present
  i_decoder i_decoder_i (
    .instr_i        (if_id_i.instr),
    .decoder_ctrl_o (decoder_i_ctrl)
  );

  generate
    if (M_EXT) begin : gen_m_decoder
      m_decoder m_decoder_i (
        .instr_i        (if_id_i.instr),
        .decoder_ctrl_o (decoder_m_ctrl)
      );
    end else begin : gen_no_m_decoder
      assign decoder_m_ctrl = DECODER_CTRL_ILLEGAL_INSN;  // MULDIV decodes illegal
    end
  endgenerate

  ////////////////////////////////////////////////////////////////////
  // Merge and suppression
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if (if_id_i.illegal_c) begin
      decoder_ctrl_mux = DECODER_CTRL_ILLEGAL_INSN;  // Expander already failed
    end else if (!decoder_m_ctrl.illegal_insn) begin
      decoder_ctrl_mux = decoder_m_ctrl;  // M match wins
    end else if (!decoder_i_ctrl.illegal_insn) begin
      decoder_ctrl_mux = decoder_i_ctrl;
    end else begin
      decoder_ctrl_mux = DECODER_CTRL_ILLEGAL_INSN;  // Nobody owns it
    end
  end

  // A faulted fetch must not act; operators still follow the word
  always_comb begin
    decoder_ctrl_o = decoder_ctrl_mux;
    if (if_id_i.fault) begin
      decoder_ctrl_o.alu_en       = 1'b0;
      decoder_ctrl_o.mul_en       = 1'b0;
      decoder_ctrl_o.div_en       = 1'b0;
      decoder_ctrl_o.lsu_en       = 1'b0;
      decoder_ctrl_o.sys_en       = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b0;
      decoder_ctrl_o.illegal_insn = 1'b0;  // Fault is reported instead
    end
  end

endmodule

// File: design/i_decoder.sv
`timescale 1ns/1ps

module i_decoder (
  input  rv_decode_pkg::instr_t        instr_i,
  output rv_decode_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import rv_decode_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////////////////////////////////
  // RV32I base decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    decoder_ctrl_o = '0;  // Fields not set below stay zero

    unique case (opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin
        decoder_ctrl_o.alu_en       = 1'b1;   // Immediate (plus PC) into rd
        decoder_ctrl_o.alu_operator = ALU_ADD;
        decoder_ctrl_o.rf_we        = 1'b1;
      end

      OPCODE_JAL: begin
        decoder_ctrl_o.alu_en       = 1'b1;   // ALU forms the link address
        decoder_ctrl_o.alu_jmp      = 1'b1;
        decoder_ctrl_o.alu_operator = ALU_ADD;
        decoder_ctrl_o.rf_we        = 1'b1;
      end

      OPCODE_JALR: begin
        if (funct3 == 3'b000) begin
          decoder_ctrl_o.alu_en       = 1'b1;
          decoder_ctrl_o.alu_jmp      = 1'b1;
          decoder_ctrl_o.alu_operator = ALU_ADD;
          decoder_ctrl_o.rf_we        = 1'b1;
          decoder_ctrl_o.rf_re        = 2'b01;  // Target base in rs1
        end else begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      OPCODE_BRANCH: begin
        decoder_ctrl_o.alu_en  = 1'b1;
        decoder_ctrl_o.alu_bch = 1'b1;
        decoder_ctrl_o.rf_re   = 2'b11;  // Compare rs1 with rs2
        case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = ALU_EQ;
          3'b001:  decoder_ctrl_o.alu_operator = ALU_NE;
          3'b100:  decoder_ctrl_o.alu_operator = ALU_LT;
          3'b101:  decoder_ctrl_o.alu_operator = ALU_GE;
          3'b110:  decoder_ctrl_o.alu_operator = ALU_LTU;
          3'b111:  decoder_ctrl_o.alu_operator = ALU_GEU;
          default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;  // 010, 011
        endcase
      end

      OPCODE_LOAD: begin
        // LB LH LW LBU LHU; funct3[2] marks the unsigned forms
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          decoder_ctrl_o.lsu_en   = 1'b1;
          decoder_ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
          decoder_ctrl_o.lsu_sext = ~funct3[2];
          decoder_ctrl_o.rf_we    = 1'b1;
          decoder_ctrl_o.rf_re    = 2'b01;
        end else begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      OPCODE_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin  // SB SH SW
          decoder_ctrl_o.lsu_en   = 1'b1;
          decoder_ctrl_o.lsu_we   = 1'b1;
          decoder_ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
          decoder_ctrl_o.rf_re    = 2'b11;  // Address base and store data
        end else begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      OPCODE_OPIMM: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
        decoder_ctrl_o.rf_re  = 2'b01;
        case (funct3)
          3'b000: decoder_ctrl_o.alu_operator = ALU_ADD;   // ADDI
          3'b010: decoder_ctrl_o.alu_operator = ALU_SLT;   // SLTI
          3'b011: decoder_ctrl_o.alu_operator = ALU_SLTU;  // SLTIU
          3'b100: decoder_ctrl_o.alu_operator = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_operator = ALU_OR;
          3'b111: decoder_ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            // SLLI needs a clean upper field
            if (funct7 == 7'b0000000) decoder_ctrl_o.alu_operator = ALU_SLL;
            else                      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
          end
          default: begin
            // 101: SRLI or SRAI, told apart by instr[30]
            if (funct7 == 7'b0000000)      decoder_ctrl_o.alu_operator = ALU_SRL;
            else if (funct7 == 7'b0100000) decoder_ctrl_o.alu_operator = ALU_SRA;
            else                           decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
          end
        endcase
      end

      OPCODE_OP: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
        decoder_ctrl_o.rf_re  = 2'b11;
        // funct7 0000001 falls through as illegal, owned by the M decoder
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: decoder_ctrl_o.alu_operator = ALU_ADD;
          {7'b0100000, 3'b000}: decoder_ctrl_o.alu_operator = ALU_SUB;
          {7'b0000000, 3'b001}: decoder_ctrl_o.alu_operator = ALU_SLL;
          {7'b0000000, 3'b010}: decoder_ctrl_o.alu_operator = ALU_SLT;
          {7'b0000000, 3'b011}: decoder_ctrl_o.alu_operator = ALU_SLTU;
          {7'b0000000, 3'b100}: decoder_ctrl_o.alu_operator = ALU_XOR;
          {7'b0000000, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRL;
          {7'b0100000, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRA;
          {7'b0000000, 3'b110}: decoder_ctrl_o.alu_operator = ALU_OR;
          {7'b0000000, 3'b111}: decoder_ctrl_o.alu_operator = ALU_AND;
          default:              decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        endcase
      end

      OPCODE_FENCE: begin
        if (funct3 == 3'b000) decoder_ctrl_o.sys_en = 1'b1;  // FENCE.I is 001
        else                  decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
      end

      OPCODE_SYSTEM: begin
        // Only ECALL and EBREAK; rd, rs1 and funct3 must all be zero
        if (instr_i[19:7] != '0) begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end else if (instr_i[31:20] == 12'h000) begin
          decoder_ctrl_o.sys_en         = 1'b1;
          decoder_ctrl_o.sys_ecall_insn = 1'b1;
        end else if (instr_i[31:20] == 12'h001) begin
          decoder_ctrl_o.sys_en        = 1'b1;
          decoder_ctrl_o.sys_ebrk_insn = 1'b1;
        end else begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;  // MRET, WFI, CSRs...
        end
      end

      default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    endcase
  end

endmodule

// File: design/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                         clk,
  input  logic                         reset_i,
  input  rv_decode_pkg::if_id_t        if_id_i,
  input  rv_decode_pkg::decoder_ctrl_t ctrl_i,   // Merged, suppressed word
  output rv_decode_pkg::id_ex_t        ex_o
);

  import rv_decode_pkg::*;

  id_ex_t ex_d;

  // Register indices sit at fixed positions in every format
  always_comb begin
    ex_d = '0;  // Bubble keeps every enable low
    if (if_id_i.valid) begin
      ex_d.valid = 1'b1;
      ex_d.ctrl  = ctrl_i;
      ex_d.rd    = if_id_i.instr[11:7];
      ex_d.rs1   = if_id_i.instr[19:15];
      ex_d.rs2   = if_id_i.instr[24:20];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_o <= '0;
    end else begin
      ex_o <= ex_d;
    end
  end

endmodule

// File: design/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,     // Fetch strobe, no handshake
  input  rv_decode_pkg::instr_t instr_i,
  input  logic                  illegal_c_insn_i,  // Bad compressed encoding
  input  logic                  instr_fault_i,     // Fetch bus fault
  output rv_decode_pkg::if_id_t if_id_o
);

  import rv_decode_pkg::*;

  if_id_t if_id_d;  // Next struct

  // Empty cycles load a cleared struct so no stale word reaches decode
  always_comb begin
    if_id_d = '0;
    if (instr_valid_i) begin
      if_id_d.valid     = 1'b1;
      if_id_d.instr     = instr_i;
      if_id_d.illegal_c = illegal_c_insn_i;
      if_id_d.fault     = instr_fault_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_id_o <= '0;
    end else begin
      if_id_o <= if_id_d;  // Advances every edge
    end
  end

endmodule

// File: design/m_decoder.sv
`timescale 1ns/1ps

module m_decoder (
  input  rv_decode_pkg::instr_t        instr_i,
  output rv_decode_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import rv_decode_pkg::*;

  logic [2:0] funct3;
  logic       m_match;  // OP with the MULDIV funct7

  assign funct3  = instr_i[14:12];
  assign m_match = (instr_i[6:0] == OPCODE_OP) && (instr_i[31:25] == 7'b0000001);

  always_comb begin
    decoder_ctrl_o = '0;
    if (!m_match) begin
      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;  // Left to the other decoders
    end else begin
      decoder_ctrl_o.rf_we = 1'b1;
      decoder_ctrl_o.rf_re = 2'b11;
      if (!funct3[2]) begin
        decoder_ctrl_o.mul_en       = 1'b1;
        decoder_ctrl_o.mul_operator = mul_opcode_e'(funct3[1:0]);
        case (funct3[1:0])
          2'b01:   decoder_ctrl_o.mul_signed_mode = 2'b11;  // MULH
          2'b10:   decoder_ctrl_o.mul_signed_mode = 2'b01;  // MULHSU, rs1 signed
          default: decoder_ctrl_o.mul_signed_mode = 2'b00;  // MUL, MULHU
        endcase
      end else begin
        decoder_ctrl_o.div_en       = 1'b1;  // DIV DIVU REM REMU
        decoder_ctrl_o.div_operator = div_opcode_e'(funct3[1:0]);
      end
    end
  end

endmodule

// File: design/rv_decode_pkg.sv
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////////////

  typedef logic [31:0] instr_t;     // Fetched instruction word
  typedef logic [4:0]  reg_addr_t;  // Register file index
  typedef logic [6:0]  opcode_t;    // Major opcode field

  // Major opcodes of the RV32I groups this stage decodes
  localparam opcode_t OPCODE_LUI    = 7'b0110111;
  localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
  localparam opcode_t OPCODE_JAL    = 7'b1101111;
  localparam opcode_t OPCODE_JALR   = 7'b1100111;
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;
  localparam opcode_t OPCODE_LOAD   = 7'b0000011;
  localparam opcode_t OPCODE_STORE  = 7'b0100011;
  localparam opcode_t OPCODE_OPIMM  = 7'b0010011;
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  localparam opcode_t OPCODE_FENCE  = 7'b0001111;  // MISC-MEM with only FENCE kept
  localparam opcode_t OPCODE_SYSTEM = 7'b1110011;  // ECALL and EBREAK only

  ////////////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,  ALU_SUB  = 5'd1,  ALU_XOR  = 5'd2,  ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,  ALU_SLL  = 5'd5,  ALU_SRL  = 5'd6,  ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,  ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd16, ALU_NE   = 5'd17, ALU_LT   = 5'd18, ALU_GE   = 5'd19,
    ALU_LTU  = 5'd20, ALU_GEU  = 5'd21   // Branch compares
  } alu_opcode_e;

  // Order follows funct3[1:0] of the M group
  typedef enum logic [1:0] {
    MUL_M   = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mul_opcode_e;

  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_opcode_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////
  // Pipeline words
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   valid;
    instr_t instr;
    logic   illegal_c;  // Compressed expander flagged it
    logic   fault;      // Fetch fault travels with the instruction
  } if_id_t;

  typedef struct packed {
    logic        illegal_insn;
    logic        alu_en;
    logic        alu_bch;
    logic        alu_jmp;
    alu_opcode_e alu_operator;
    logic        mul_en;
    mul_opcode_e mul_operator;
    logic [1:0]  mul_signed_mode;  // {op_b signed, op_a signed}
    logic        div_en;
    div_opcode_e div_operator;
    logic        lsu_en;
    logic        lsu_we;
    lsu_size_e   lsu_size;
    logic        lsu_sext;
    logic        rf_we;
    logic [1:0]  rf_re;            // {rs2, rs1} read enables
    logic        sys_en;
    logic        sys_ecall_insn;
    logic        sys_ebrk_insn;
  } decoder_ctrl_t;

  // Word a sub-decoder returns when it does not own the encoding
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn    : 1'b1,
    alu_en          : 1'b0,
    alu_bch         : 1'b0,
    alu_jmp         : 1'b0,
    alu_operator    : ALU_ADD,
    mul_en          : 1'b0,
    mul_operator    : MUL_M,
    mul_signed_mode : 2'b00,
    div_en          : 1'b0,
    div_operator    : DIV_DIV,
    lsu_en          : 1'b0,
    lsu_we          : 1'b0,
    lsu_size        : LSU_BYTE,
    lsu_sext        : 1'b0,
    rf_we           : 1'b0,
    rf_re           : 2'b00,
    sys_en          : 1'b0,
    sys_ecall_insn  : 1'b0,
    sys_ebrk_insn   : 1'b0
  };

  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;
    reg_addr_t     rd;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
  } id_ex_t;

endpackage

// File: files.f
design/rv_decode_pkg.sv
design/if_id_reg.sv
design/i_decoder.sv
design/m_decoder.sv
design/decoder.sv
design/id_ex_reg.sv
design/decode_stage.sv
tests/clk_gen.sv
tests/decode_stage_chk.sv
tests/decode_stage_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module decode_stage_tb -f files.f \
  && ./obj_dir/Vdecode_stage_tb | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset drops just after an edge, like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// File: tests/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk (
  input logic                  clk,
  input logic                  reset_i,
  input rv_decode_pkg::id_ex_t ex_i
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run

  ////////////////////////////////////////////////////////////////////
  // Output word properties
  ////////////////////////////////////////////////////////////////////

  // Reset clears the ID/EX register
  reset_clears_valid: assert property (@(posedge clk) reset_i |=> !ex_i.valid)
    else begin
      $error("ex_o valid is set in the cycle after reset");
      fail_cnt++;
    end

  // One execution unit per instruction
  one_unit_enabled: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({ex_i.ctrl.alu_en, ex_i.ctrl.lsu_en, ex_i.ctrl.mul_en, ex_i.ctrl.div_en}))
    else begin
      $error("more than one unit enable set in ex_o");
      fail_cnt++;
    end

  illegal_is_inert: assert property (@(posedge clk) disable iff (reset_i)
    ex_i.ctrl.illegal_insn |-> !(ex_i.ctrl.alu_en | ex_i.ctrl.lsu_en | ex_i.ctrl.mul_en |
                                 ex_i.ctrl.div_en | ex_i.ctrl.sys_en | ex_i.ctrl.rf_we))
    else begin
      $error("illegal instruction carries an enable");
      fail_cnt++;
    end

endmodule

bind decode_stage decode_stage_chk chk (
  .clk     (clk),
  .reset_i (reset_i),
  .ex_i    (ex_o)
);

// File: tests/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

  import rv_decode_pkg::*;

  localparam bit M_EXT         = 1'b1;
  localparam int NUM_TESTS     = 2000;
  localparam int RESET_TIMEOUT = 50;   // Cycles

  logic   clk;
  logic   reset_i;
  logic   instr_valid_i;
  instr_t instr_i;
  logic   illegal_c_insn_i;
  logic   instr_fault_i;
  id_ex_t ex_o;

  logic [31:0] rng_state = 32'd39;
  id_ex_t      exp_q[$];   // Expected words, two edges deep
  string       name_q[$];  // Test name per expected word

  clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) clk_gen_i (
    .clk_o   (clk),
    .reset_o (reset_i)
  );

  decode_stage #(.M_EXT(M_EXT)) dut (
    .clk              (clk),
    .reset_i          (reset_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .instr_fault_i    (instr_fault_i),
    .ex_o             (ex_o)
  );

  ////////////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic decoder_ctrl_t expect_ctrl(input instr_t in, input logic ill_c,
                                                input logic flt);
    decoder_ctrl_t c;
    logic [6:0]    op;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          ok;
    op = in[6:0];
    f3 = in[14:12];
    f7 = in[31:25];
    c  = '0;
    ok = 1'b1;
    if (M_EXT && op == OPCODE_OP && f7 == 7'b0000001) begin
      c.rf_we = 1'b1;
      c.rf_re = 2'b11;
      case (f3)
        3'd0: c.mul_operator = MUL_M;   // Low word, unsigned mode
        3'd1: begin
          c.mul_operator    = MUL_H;
          c.mul_signed_mode = 2'b11;
        end
        3'd2: begin
          c.mul_operator    = MUL_HSU;  // Only rs1 signed
          c.mul_signed_mode = 2'b01;
        end
        3'd3: c.mul_operator = MUL_HU;
        3'd4: c.div_operator = DIV_DIV;
        3'd5: c.div_operator = DIV_DIVU;
        3'd6: c.div_operator = DIV_REM;
        default: c.div_operator = DIV_REMU;
      endcase
      c.mul_en = ~f3[2];
      c.div_en = f3[2];
    end else begin
      case (op)
        OPCODE_LUI, OPCODE_AUIPC: begin
          c.alu_en = 1'b1;
          c.rf_we  = 1'b1;
        end
        OPCODE_JAL, OPCODE_JALR: begin
          c.alu_en  = 1'b1;
          c.alu_jmp = 1'b1;
          c.rf_we   = 1'b1;
          c.rf_re   = (op == OPCODE_JALR) ? 2'b01 : 2'b00;
          ok        = (op == OPCODE_JAL) || (f3 == 3'b000);
        end
        OPCODE_BRANCH: begin
          c.alu_en  = 1'b1;
          c.alu_bch = 1'b1;
          c.rf_re   = 2'b11;
          case (f3)
            3'b000:  c.alu_operator = ALU_EQ;
            3'b001:  c.alu_operator = ALU_NE;
            3'b100:  c.alu_operator = ALU_LT;
            3'b101:  c.alu_operator = ALU_GE;
            3'b110:  c.alu_operator = ALU_LTU;
            3'b111:  c.alu_operator = ALU_GEU;
            default: ok = 1'b0;
          endcase
        end
        OPCODE_LOAD, OPCODE_STORE: begin
          c.lsu_en = 1'b1;
          case (f3[1:0])
            2'b00:   c.lsu_size = LSU_BYTE;
            2'b01:   c.lsu_size = LSU_HALF;
            default: c.lsu_size = LSU_WORD;
          endcase
          if (op == OPCODE_LOAD) begin
            c.lsu_sext = ~f3[2];  // LBU and LHU zero extend
            c.rf_we    = 1'b1;
            c.rf_re    = 2'b01;
            ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
          end else begin
            c.lsu_we = 1'b1;
            c.rf_re  = 2'b11;
            ok       = (f3 < 3'd3);
          end
        end
        OPCODE_OPIMM, OPCODE_OP: begin
          c.alu_en = 1'b1;
          c.rf_we  = 1'b1;
          c.rf_re  = (op == OPCODE_OP) ? 2'b11 : 2'b01;
          case (f3)
            3'b000: c.alu_operator = (op == OPCODE_OP && f7[5]) ? ALU_SUB : ALU_ADD;
            3'b001: c.alu_operator = ALU_SLL;
            3'b010: c.alu_operator = ALU_SLT;
            3'b011: c.alu_operator = ALU_SLTU;
            3'b100: c.alu_operator = ALU_XOR;
            3'b101: c.alu_operator = f7[5] ? ALU_SRA : ALU_SRL;
            3'b110: c.alu_operator = ALU_OR;
            default: c.alu_operator = ALU_AND;
          endcase
          // Upper field only matters for shifts, and for SUB in OP
          if (op == OPCODE_OP)
            ok = (f7 == 7'b0000000) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
          else if (f3 == 3'b001)
            ok = (f7 == 7'b0000000);
          else if (f3 == 3'b101)
            ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
        end
        OPCODE_FENCE: begin
          c.sys_en = 1'b1;
          ok       = (f3 == 3'b000);
        end
        OPCODE_SYSTEM: begin
          c.sys_en         = 1'b1;
          c.sys_ecall_insn = ~in[20];
          c.sys_ebrk_insn  = in[20];
          ok = (in[19:7] == 13'd0) && (in[31:21] == 11'd0);
        end
        default: ok = 1'b0;
      endcase
    end
    if (!ok || ill_c) begin
      c              = '0;
      c.illegal_insn = 1'b1;
    end
    if (flt) begin  // Enables off, operators kept
      c.alu_en       = 1'b0;
      c.mul_en       = 1'b0;
      c.div_en       = 1'b0;
      c.lsu_en       = 1'b0;
      c.sys_en       = 1'b0;
      c.rf_we        = 1'b0;
      c.illegal_insn = 1'b0;
    end
    return c;
  endfunction

  function automatic id_ex_t expect_word(input logic valid, input instr_t in,
                                         input logic ill_c, input logic flt);
    id_ex_t e;
    e = '0;  // Bubble
    if (valid) begin
      e.valid = 1'b1;
      e.ctrl  = expect_ctrl(in, ill_c, flt);
      e.rd    = in[11:7];
      e.rs1   = in[19:15];
      e.rs2   = in[24:20];
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("FAIL: see errors above");
    $fatal(1, "%s", why);
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] f;
    logic [31:0] v;
    int unsigned cls;
    instr_t      instr;
    string       tname;
    next_rand(r);
    next_rand(c);
    next_rand(f);
    next_rand(v);
    cls   = c % 32'd13;
    instr = r;  // Register fields and immediates stay random
    case (cls)
      0: begin
        tname       = "lui";
        instr[6:0]  = OPCODE_LUI;
      end
      1: begin
        tname       = "auipc";
        instr[6:0]  = OPCODE_AUIPC;
      end
      2: begin
        tname       = "jal";
        instr[6:0]  = OPCODE_JAL;
      end
      3: begin
        tname      = "jalr";
        instr[6:0] = OPCODE_JALR;
        if (f[1:0] != 2'b00) instr[14:12] = 3'b000;  // Mostly legal
      end
      4: begin
        tname      = "branch";
        instr[6:0] = OPCODE_BRANCH;
      end
      5: begin
        tname      = "load";
        instr[6:0] = OPCODE_LOAD;
      end
      6: begin
        tname      = "store";
        instr[6:0] = OPCODE_STORE;
      end
      7: begin
        tname      = "op_imm";
        instr[6:0] = OPCODE_OPIMM;
        if (f[2:1] != 2'b00) instr[31:25] = f[0] ? 7'b0100000 : 7'b0000000;
      end
      8: begin
        tname      = "op";
        instr[6:0] = OPCODE_OP;
        if (f[3:1] != 3'b000) instr[31:25] = f[0] ? 7'b0100000 : 7'b0000000;
      end
      9: begin
        tname      = "fence";
        instr[6:0] = OPCODE_FENCE;
        if (f[1:0] != 2'b00) instr[14:12] = 3'b000;
      end
      10: begin
        tname      = "system";
        instr[6:0] = OPCODE_SYSTEM;
        if (f[3:1] != 3'b000) begin
          instr[19:7]  = 13'd0;
          instr[31:20] = f[0] ? 12'h001 : 12'h000;  // EBREAK or ECALL
        end
      end
      11: begin
        tname        = "muldiv";
        instr[6:0]   = OPCODE_OP;
        instr[31:25] = 7'b0000001;
      end
      default: begin
        tname = "unsupported";
        case (f[1:0])
          2'd0:    instr[6:0] = 7'b0101111;  // AMO
          2'd1:    instr[6:0] = 7'b0000111;  // LOAD-FP
          2'd2:    instr[6:0] = 7'b1010011;  // OP-FP
          default: instr[6:0] = 7'b0011011;  // OP-IMM-32
        endcase
      end
    endcase
    instr_valid_i    = (v[2:0] != 3'b000);
    illegal_c_insn_i = (v[7:4] == 4'h0);
    instr_fault_i    = (v[11:8] == 4'h0);
    instr_i          = instr;
    if (!instr_valid_i) tname = "idle";
    else if (illegal_c_insn_i) tname = {tname, "_illegal_c"};
    if (instr_valid_i && instr_fault_i) tname = {tname, "_fault"};
    exp_q.push_back(expect_word(instr_valid_i, instr, illegal_c_insn_i, instr_fault_i));
    name_q.push_back(tname);
  endtask

  task automatic drive_idle(input string tname);
    instr_valid_i    = 1'b0;
    instr_i          = '0;
    illegal_c_insn_i = 1'b0;
    instr_fault_i    = 1'b0;
    exp_q.push_back(expect_word(1'b0, '0, 1'b0, 1'b0));
    name_q.push_back(tname);
  endtask

  task automatic check_output();
    id_ex_t exp_word;
    string  tname;
    exp_word = exp_q.pop_front();
    tname    = name_q.pop_front();
    assert (ex_o === exp_word) else begin
      $display("ERROR: %s expected %h actual %h", tname, exp_word, ex_o);
      abort_run("ex_o differs from the reference model");
    end
  endtask

  initial begin : run
    int unsigned wait_cycles;
    instr_valid_i    = 1'b0;
    instr_i          = '0;
    illegal_c_insn_i = 1'b0;
    instr_fault_i    = 1'b0;

    wait_cycles = 0;
    do begin
      if (wait_cycles == RESET_TIMEOUT) begin
        abort_run("reset was never released");
      end else begin
        @(posedge clk);
        wait_cycles++;
      end
    end while (reset_i);

    // Words already in flight come from reset and the idle inputs
    exp_q.push_back(expect_word(1'b0, '0, 1'b0, 1'b0));
    name_q.push_back("reset");
    exp_q.push_back(expect_word(1'b0, '0, 1'b0, 1'b0));
    name_q.push_back("reset");

    for (int i = 0; i < NUM_TESTS + 2; i++) begin
      @(posedge clk);
      #2;
      check_output();  // Word driven two edges back
      if (i < NUM_TESTS) drive_random();
      else               drive_idle("drain");
    end

    if (dut.chk.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("bound assertions on decode_stage failed");
    end
  end

endmodule
